/* hdl/slc3_defs.svh */
// SLC-3 build constants, included by every RTL file that needs the reset PC, I/O map or wait
`ifndef SLC3_DEFS_SVH
`define SLC3_DEFS_SVH

// ------------------------------
// Reset and address map
// ------------------------------

// First instruction fetched after reset
`define SLC3_RESET_PC 16'h0000

// Switches on read, hex display register on write
`define SLC3_IO_ADDR 16'hFFFF

// Cycles a memory strobe stays high
`define SLC3_MEM_WAIT 2

`endif

/* hdl/slc3Pkg.sv */
// Shared SLC-3 types, referenced by scoped name from the datapath, controller, bridge and top
package slc3Pkg;

    // Data and address word
    typedef logic [15:0] word_t;
    // General register number
    typedef logic [2:0] regIdx_t;
    // IR[15:12]
    typedef logic [3:0] opcode_t;

    // Controller states, fetch2/ldWait/stWait repeat during the memory wait
    typedef enum logic [3:0] {
        halt, fetch1, fetch2, fetch3, decode,
        exAlu, exBr, exJmp,
        memAddr, ldWait, ldWrite,
        stData, stWait,
        pause1, pause2
    } ctrlState_t;

    // Datapath controls
    typedef struct packed {
        // Register loads
        logic ldMar, ldMdr, ldIr, ldBen, ldCc, ldReg, ldPc, ldLed;
        // Bus drivers, one at a time
        logic gatePc, gateMdr, gateAlu, gateMarMux;
        // Mux selects
        logic [1:0] pcMux;
        logic [1:0] addr2Mux;
        logic addr1Mux, drMux, sr1Mux, sr2Mux;
        logic [1:0] aluK;
        logic mioEn;
    } ctrl_t;

    // Memory request as seen on the external port
    typedef struct packed {
        word_t addr;
        word_t wdata;
        logic ce, oe, we;
    } memReq_t;

endpackage

/* hdl/regFile.sv */
// Eight-entry register file for the SLC-3 datapath, two async reads and one clocked write
`timescale 1ns/10ps

module regFile (
    input  logic             Clk,
    input  logic             arstN,
    input  logic             we,
    input  slc3Pkg::regIdx_t wrIdx,
    input  slc3Pkg::regIdx_t rdIdxA,
    input  slc3Pkg::regIdx_t rdIdxB,
    input  slc3Pkg::word_t   wrData,
    output slc3Pkg::word_t   rdDataA,
    output slc3Pkg::word_t   rdDataB
);

    // R0..R7
    slc3Pkg::word_t regs [8];

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[wrIdx] <= wrData;
        end
    end

    // Read ports see the old value during a write cycle
    assign rdDataA = regs[rdIdxA];
    assign rdDataB = regs[rdIdxB];

endmodule

/* hdl/datapath.sv */
// SLC-3 datapath with PC, IR, MAR, MDR, ALU, address adder, shared bus and condition codes
`timescale 1ns/10ps
`include "slc3_defs.svh"

module datapath (
    input  logic           Clk,
    input  logic           arstN,
    input  slc3Pkg::ctrl_t ctrl,
    input  slc3Pkg::word_t memRdata,
    output slc3Pkg::word_t memAddr,
    output slc3Pkg::word_t memWdata,
    output slc3Pkg::word_t ir,
    output slc3Pkg::word_t pc,
    output logic           ben,
    output logic [11:0]    led
);

    slc3Pkg::word_t pcReg, irReg, marReg, mdrReg;
    slc3Pkg::word_t bus, aluOut, addrSum, addr1, addr2, pcNext, mdrIn;
    slc3Pkg::word_t srA, srB, aluB;
    slc3Pkg::regIdx_t sr1Idx, drIdx;
    logic [2:0] nzp;
    logic [11:0] ledReg;
    logic benReg;

    // ------------------------------
    // Register file
    // ------------------------------

    // SR1 from IR[8:6] for ALU and base, IR[11:9] for store source
    assign sr1Idx = ctrl.sr1Mux ? irReg[8:6] : irReg[11:9];
    // R7 path kept for link writes
    assign drIdx = ctrl.drMux ? 3'd7 : irReg[11:9];

    regFile uRegFile (
        .Clk     (Clk),
        .arstN   (arstN),
        .we      (ctrl.ldReg),
        .wrIdx   (drIdx),
        .rdIdxA  (sr1Idx),
        .rdIdxB  (irReg[2:0]),
        .wrData  (bus),
        .rdDataA (srA),
        .rdDataB (srB)
    );

    // ------------------------------
    // ALU and address adder
    // ------------------------------

    // Immediate is sign-extended IR[4:0]
    assign aluB = ctrl.sr2Mux ? {{11{irReg[4]}}, irReg[4:0]} : srB;

    always_comb begin
        case (ctrl.aluK)
            2'b00:   aluOut = srA + aluB;
            2'b01:   aluOut = srA & aluB;
            2'b10:   aluOut = ~srA;
            default: aluOut = srA;
        endcase
    end

    // Base is PC or SR1
    assign addr1 = ctrl.addr1Mux ? srA : pcReg;

    // Offset6 for LDR/STR, offset9 for BR
    always_comb begin
        case (ctrl.addr2Mux)
            2'b00:   addr2 = '0;
            2'b01:   addr2 = {{10{irReg[5]}}, irReg[5:0]};
            2'b10:   addr2 = {{7{irReg[8]}}, irReg[8:0]};
            default: addr2 = {{5{irReg[10]}}, irReg[10:0]};
        endcase
    end

    assign addrSum = addr1 + addr2;

    // ------------------------------
    // Bus and registers
    // ------------------------------

    always_comb begin
        if (ctrl.gatePc) begin
            bus = pcReg;
        end else if (ctrl.gateMdr) begin
            bus = mdrReg;
        end else if (ctrl.gateAlu) begin
            bus = aluOut;
        end else if (ctrl.gateMarMux) begin
            bus = addrSum;
        end else begin
            bus = '0;
        end
    end

    always_comb begin
        case (ctrl.pcMux)
            2'b00:   pcNext = pcReg + 16'd1;
            2'b01:   pcNext = bus;
            2'b10:   pcNext = addrSum;
            default: pcNext = pcReg;
        endcase
    end

    // Memory side during strobes, bus otherwise
    assign mdrIn = ctrl.mioEn ? memRdata : bus;

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            pcReg  <= `SLC3_RESET_PC;
            nzp    <= '0;
            benReg <= 1'b0;
            ledReg <= '0;
        end else begin
            if (ctrl.ldPc) begin
                pcReg <= pcNext;
            end
            // Flags follow the value written to the register file
            if (ctrl.ldCc) begin
                nzp <= {bus[15], bus == '0, !bus[15] && bus != '0};
            end
            if (ctrl.ldBen) begin
                benReg <= |(irReg[11:9] & nzp);
            end
            if (ctrl.ldLed) begin
                ledReg <= irReg[11:0];
            end
        end
    end

    // Payload registers
    always_ff @(posedge Clk) begin
        if (ctrl.ldMar) begin
            marReg <= bus;
        end
        if (ctrl.ldMdr) begin
            mdrReg <= mdrIn;
        end
        if (ctrl.ldIr) begin
            irReg <= bus;
        end
    end

    assign memAddr  = marReg;
    assign memWdata = mdrReg;
    assign ir       = irReg;
    assign pc       = pcReg;
    assign ben      = benReg;
    assign led      = ledReg;

    // Controller never drives two sources onto the bus
    assert property (@(posedge Clk) disable iff (!arstN)
        $onehot0({ctrl.gatePc, ctrl.gateMdr, ctrl.gateAlu, ctrl.gateMarMux}));

endmodule

/* hdl/controlUnit.sv */
// SLC-3 multicycle controller, sequences fetch, decode and execute and drives memory strobes
`timescale 1ns/10ps
`include "slc3_defs.svh"

module controlUnit (
    input  logic             Clk,
    input  logic             arstN,
    input  logic             run,
    input  logic             resume,
    input  slc3Pkg::opcode_t opcode,
    input  logic             irBit5,
    input  logic             irBit11,
    input  logic             ben,
    output slc3Pkg::ctrl_t   ctrl,
    output logic             memCe,
    output logic             memOe,
    output logic             memWe
);

    // Supported opcodes
    localparam slc3Pkg::opcode_t OpBr    = 4'b0000;
    localparam slc3Pkg::opcode_t OpAdd   = 4'b0001;
    localparam slc3Pkg::opcode_t OpAnd   = 4'b0101;
    localparam slc3Pkg::opcode_t OpLdr   = 4'b0110;
    localparam slc3Pkg::opcode_t OpStr   = 4'b0111;
    localparam slc3Pkg::opcode_t OpNot   = 4'b1001;
    localparam slc3Pkg::opcode_t OpJmp   = 4'b1100;
    localparam slc3Pkg::opcode_t OpPause = 4'b1101;

    slc3Pkg::ctrlState_t state, nextState;
    logic [3:0] waitCnt;
    logic inWait, lastWait;

    // ------------------------------
    // Memory wait counter
    // ------------------------------

    assign inWait = state inside {slc3Pkg::fetch2, slc3Pkg::ldWait, slc3Pkg::stWait};
    assign lastWait = waitCnt == 4'(`SLC3_MEM_WAIT - 1);

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            state   <= slc3Pkg::halt;
            waitCnt <= '0;
        end else begin
            state <= nextState;
            // Restart for every strobe
            if (inWait && !lastWait) begin
                waitCnt <= waitCnt + 4'd1;
            end else begin
                waitCnt <= '0;
            end
        end
    end

    // ------------------------------
    // Next state
    // ------------------------------

    always_comb begin
        nextState = state;
        case (state)
            slc3Pkg::halt:   if (run) nextState = slc3Pkg::fetch1;
            slc3Pkg::fetch1: nextState = slc3Pkg::fetch2;
            slc3Pkg::fetch2: if (lastWait) nextState = slc3Pkg::fetch3;
            slc3Pkg::fetch3: nextState = slc3Pkg::decode;
            slc3Pkg::decode: begin
                case (opcode)
                    OpAdd, OpAnd, OpNot: nextState = slc3Pkg::exAlu;
                    OpBr:                nextState = slc3Pkg::exBr;
                    // Reserved field of JMP must be zero
                    OpJmp:   nextState = irBit11 ? slc3Pkg::fetch1 : slc3Pkg::exJmp;
                    OpLdr, OpStr:        nextState = slc3Pkg::memAddr;
                    OpPause:             nextState = slc3Pkg::pause1;
                    // Unsupported, treat as no-op
                    default:             nextState = slc3Pkg::fetch1;
                endcase
            end
            slc3Pkg::memAddr: begin
                nextState = (opcode == OpLdr) ? slc3Pkg::ldWait : slc3Pkg::stData;
            end
            slc3Pkg::ldWait:  if (lastWait) nextState = slc3Pkg::ldWrite;
            slc3Pkg::stData:  nextState = slc3Pkg::stWait;
            slc3Pkg::stWait:  if (lastWait) nextState = slc3Pkg::fetch1;
            slc3Pkg::pause1:  if (resume) nextState = slc3Pkg::pause2;
            // Hold until the button is released
            slc3Pkg::pause2:  if (!resume) nextState = slc3Pkg::fetch1;
            default:          nextState = slc3Pkg::fetch1;
        endcase
    end

    // ------------------------------
    // Control outputs
    // ------------------------------

    always_comb begin
        ctrl = '0;
        case (state)
            // MAR <- PC, PC <- PC + 1
            slc3Pkg::fetch1: begin
                ctrl.gatePc = 1'b1;
                ctrl.ldMar  = 1'b1;
                ctrl.ldPc   = 1'b1;
            end
            slc3Pkg::fetch2, slc3Pkg::ldWait: begin
                ctrl.mioEn = 1'b1;
                ctrl.ldMdr = lastWait;
            end
            slc3Pkg::fetch3: begin
                ctrl.gateMdr = 1'b1;
                ctrl.ldIr    = 1'b1;
            end
            slc3Pkg::decode: ctrl.ldBen = 1'b1;
            slc3Pkg::exAlu: begin
                ctrl.sr1Mux  = 1'b1;
                ctrl.sr2Mux  = irBit5;
                ctrl.gateAlu = 1'b1;
                ctrl.ldReg   = 1'b1;
                ctrl.ldCc    = 1'b1;
                case (opcode)
                    OpAnd:   ctrl.aluK = 2'b01;
                    OpNot:   ctrl.aluK = 2'b10;
                    default: ctrl.aluK = 2'b00;
                endcase
            end
            // PC + offset9 when the mask matches
            slc3Pkg::exBr: begin
                ctrl.addr2Mux = 2'b10;
                ctrl.pcMux    = 2'b10;
                ctrl.ldPc     = ben;
            end
            // Base register through the ALU onto the bus
            slc3Pkg::exJmp: begin
                ctrl.sr1Mux  = 1'b1;
                ctrl.aluK    = 2'b11;
                ctrl.gateAlu = 1'b1;
                ctrl.pcMux   = 2'b01;
                ctrl.ldPc    = 1'b1;
            end
            slc3Pkg::memAddr: begin
                ctrl.sr1Mux     = 1'b1;
                ctrl.addr1Mux   = 1'b1;
                ctrl.addr2Mux   = 2'b01;
                ctrl.gateMarMux = 1'b1;
                ctrl.ldMar      = 1'b1;
            end
            slc3Pkg::ldWrite: begin
                ctrl.gateMdr = 1'b1;
                ctrl.ldReg   = 1'b1;
                ctrl.ldCc    = 1'b1;
            end
            // Store source is IR[11:9]
            slc3Pkg::stData: begin
                ctrl.aluK    = 2'b11;
                ctrl.gateAlu = 1'b1;
                ctrl.ldMdr   = 1'b1;
            end
            slc3Pkg::pause1: ctrl.ldLed = 1'b1;
            default: ;
        endcase
    end

    assign memCe = inWait;
    assign memOe = state inside {slc3Pkg::fetch2, slc3Pkg::ldWait};
    assign memWe = state == slc3Pkg::stWait;

    // Read and write strobes are exclusive
    assert property (@(posedge Clk) disable iff (!arstN) !(memOe && memWe));

    // Chip enable pulse has the fixed wait length
    assert property (@(posedge Clk) disable iff (!arstN)
        $rose(memCe) |-> memCe [*`SLC3_MEM_WAIT] ##1 !memCe);

endmodule

/* hdl/memBridge.sv */
// Memory and I/O bridge, passes CPU accesses to SRAM or serves the switch/display word
`timescale 1ns/10ps
`include "slc3_defs.svh"

module memBridge (
    input  logic             Clk,
    input  logic             arstN,
    input  slc3Pkg::memReq_t cpuReq,
    output slc3Pkg::word_t   cpuRdata,
    output slc3Pkg::memReq_t memReq,
    input  slc3Pkg::word_t   memRdata,
    input  slc3Pkg::word_t   switches,
    output slc3Pkg::word_t   hexValue
);

    logic isIo, ioWrite, ioWrLast;
    logic [3:0] ioWrCnt;

    assign isIo = cpuReq.addr == `SLC3_IO_ADDR;
    assign ioWrite = isIo && cpuReq.we;
    assign ioWrLast = ioWrCnt == 4'(`SLC3_MEM_WAIT - 1);

    // SRAM never sees the I/O word
    always_comb begin
        memReq    = cpuReq;
        memReq.ce = cpuReq.ce && !isIo;
        memReq.oe = cpuReq.oe && !isIo;
        memReq.we = cpuReq.we && !isIo;
    end

    assign cpuRdata = isIo ? switches : memRdata;

    // Display word takes the data on the last write cycle
    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            ioWrCnt  <= '0;
            hexValue <= '0;
        end else if (ioWrite) begin
            ioWrCnt <= ioWrLast ? 4'd0 : ioWrCnt + 4'd1;
            if (ioWrLast) begin
                hexValue <= cpuReq.wdata;
            end
        end else begin
            ioWrCnt <= '0;
        end
    end

endmodule

/* hdl/slc3.sv */
// SLC-3 top level, connects controller, datapath and memory bridge to the external ports
`timescale 1ns/10ps

module slc3 (
    input  logic             Clk,
    input  logic             arstN,
    input  logic             run,
    input  logic             resume,
    input  slc3Pkg::word_t   switches,
    input  slc3Pkg::word_t   memRdata,
    output slc3Pkg::memReq_t memReq,
    output logic [11:0]      led,
    output slc3Pkg::word_t   hexValue,
    output slc3Pkg::word_t   pc
);

    slc3Pkg::ctrl_t ctrl;
    slc3Pkg::memReq_t cpuReq;
    slc3Pkg::word_t ir, cpuRdata;
    logic ben;

    controlUnit uControl (
        .Clk     (Clk),
        .arstN   (arstN),
        .run     (run),
        .resume  (resume),
        .opcode  (ir[15:12]),
        .irBit5  (ir[5]),
        .irBit11 (ir[11]),
        .ben     (ben),
        .ctrl    (ctrl),
        .memCe   (cpuReq.ce),
        .memOe   (cpuReq.oe),
        .memWe   (cpuReq.we)
    );

    // Address from MAR, write data from MDR
    datapath uDatapath (
        .Clk      (Clk),
        .arstN    (arstN),
        .ctrl     (ctrl),
        .memRdata (cpuRdata),
        .memAddr  (cpuReq.addr),
        .memWdata (cpuReq.wdata),
        .ir       (ir),
        .pc       (pc),
        .ben      (ben),
        .led      (led)
    );

    memBridge uBridge (
        .Clk      (Clk),
        .arstN    (arstN),
        .cpuReq   (cpuReq),
        .cpuRdata (cpuRdata),
        .memReq   (memReq),
        .memRdata (memRdata),
        .switches (switches),
        .hexValue (hexValue)
    );

endmodule

/* test/slc3Tb.sv */
// Directed testbench for the SLC-3 top level, with an SRAM model and one task per program
`timescale 1ns/10ps
`include "slc3_defs.svh"

module slc3Tb;

    // LC-3 opcodes used by the test programs
    localparam slc3Pkg::opcode_t OpBr    = 4'b0000;
    localparam slc3Pkg::opcode_t OpAdd   = 4'b0001;
    localparam slc3Pkg::opcode_t OpAnd   = 4'b0101;
    localparam slc3Pkg::opcode_t OpLdr   = 4'b0110;
    localparam slc3Pkg::opcode_t OpStr   = 4'b0111;
    localparam slc3Pkg::opcode_t OpNot   = 4'b1001;
    localparam slc3Pkg::opcode_t OpJmp   = 4'b1100;
    localparam slc3Pkg::opcode_t OpPause = 4'b1101;

    // Upper bound of instructions executed over all programs
    localparam int InstrCount = 13 + 7 + 41 + 6 + 4 + 6;
    localparam int TimeoutCycles = 20 * InstrCount + 200;

    logic Clk = 1'b0;
    logic arstN, run, resume;
    slc3Pkg::word_t switches, memRdata, hexValue, pc;
    slc3Pkg::memReq_t memReq;
    logic [11:0] led;

    slc3Pkg::word_t mem [0:65535];
    slc3Pkg::word_t progWords [$];
    int weCycles = 0;
    int cycles = 0;
    int checks = 0;
    int errors = 0;
    int seed = 73627;

    always #50 Clk = ~Clk;

    slc3 UUT (
        .Clk      (Clk),
        .arstN    (arstN),
        .run      (run),
        .resume   (resume),
        .switches (switches),
        .memRdata (memRdata),
        .memReq   (memReq),
        .led      (led),
        .hexValue (hexValue),
        .pc       (pc)
    );

    // ------------------------------
    // SRAM model and watchdog
    // ------------------------------

    assign memRdata = memReq.oe ? mem[memReq.addr] : 16'h0000;

    // Write lands on the last strobe cycle
    always @(posedge Clk) begin
        if (memReq.we) begin
            if (weCycles == `SLC3_MEM_WAIT - 1) begin
                mem[memReq.addr] = memReq.wdata;
                weCycles <= 0;
            end else begin
                weCycles <= weCycles + 1;
            end
        end else begin
            weCycles <= 0;
        end
        assert (!(memReq.we && memReq.addr == `SLC3_IO_ADDR)) else begin
            errors++;
            $display("External write strobe reached the I/O address");
        end
        // Chip enable rides along with either strobe
        assert (memReq.ce == (memReq.oe || memReq.we)) else begin
            errors++;
            $display("MISMATCH memReq.ce: expected %h, actual %h",
                memReq.oe || memReq.we, memReq.ce);
        end
    end

    always @(posedge Clk) begin
        cycles <= cycles + 1;
        if (cycles == TimeoutCycles) begin
            $display("Timeout: no finish after %0d cycles, checks %0d, errors %0d",
                cycles, checks, errors + 1);
            $display("Errors found");
            $finish;
        end
    end

    // ------------------------------
    // Instruction encoding
    // ------------------------------

    function automatic slc3Pkg::word_t aluReg(slc3Pkg::opcode_t op, int dr, int sr1, int sr2);
        return {op, 3'(dr), 3'(sr1), 3'b000, 3'(sr2)};
    endfunction

    function automatic slc3Pkg::word_t aluImm(slc3Pkg::opcode_t op, int dr, int sr1, int imm);
        return {op, 3'(dr), 3'(sr1), 1'b1, 5'(imm)};
    endfunction

    function automatic slc3Pkg::word_t notReg(int dr, int sr);
        return {OpNot, 3'(dr), 3'(sr), 6'h3F};
    endfunction

    // LDR or STR
    function automatic slc3Pkg::word_t memOp(slc3Pkg::opcode_t op, int r, int base, int off);
        return {op, 3'(r), 3'(base), 6'(off)};
    endfunction

    function automatic slc3Pkg::word_t branch(int nzp, int off);
        return {OpBr, 3'(nzp), 9'(off)};
    endfunction

    function automatic slc3Pkg::word_t jump(int base);
        return {OpJmp, 3'b000, 3'(base), 6'h00};
    endfunction

    function automatic slc3Pkg::word_t pauseCode(int code);
        return {OpPause, 12'(code)};
    endfunction

    // ------------------------------
    // Reference rules
    // ------------------------------

    // Sign extension of IR[4:0]
    function automatic slc3Pkg::word_t immValue(int imm);
        logic [4:0] field;
        field = 5'(imm);
        return {{11{field[4]}}, field};
    endfunction

    // Base plus sign-extended IR[5:0]
    function automatic slc3Pkg::word_t offsetAddr(slc3Pkg::word_t base, int off);
        logic [5:0] field;
        field = 6'(off);
        return base + {{10{field[5]}}, field};
    endfunction

    // N, Z and P of a two's complement word
    function automatic logic [2:0] nzpOf(slc3Pkg::word_t v);
        return {$signed(v) < 0, v == 16'h0000, $signed(v) > 0};
    endfunction

    function automatic slc3Pkg::word_t fillWord(slc3Pkg::word_t a);
        return a ^ 16'hC3A5;
    endfunction

    // ------------------------------
    // Drive and check tasks
    // ------------------------------

    task automatic checkWord(string name, slc3Pkg::word_t expected, slc3Pkg::word_t actual);
        checks++;
        assert (actual == expected) else begin
            errors++;
            $display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // Pattern everywhere, then program words from address 0
    task automatic loadProgram();
        for (int a = 0; a < 65536; a++) begin
            mem[a[15:0]] = fillWord(a[15:0]);
        end
        for (int i = 0; i < progWords.size(); i++) begin
            mem[i[15:0]] = progWords[i];
        end
    endtask

    task automatic applyReset();
        @(posedge Clk);
        arstN <= 1'b0;
        repeat (10) @(posedge Clk);
        arstN <= 1'b1;
        @(negedge Clk);
        checkWord("pc", `SLC3_RESET_PC, pc);
        checkWord("led", 16'h0000, {4'h0, led});
        checkWord("hexValue", 16'h0000, hexValue);
        checkWord("memReq.ce/oe/we", 16'h0000, {13'h0, memReq.ce, memReq.oe, memReq.we});
    endtask

    task automatic runUntilPause();
        @(posedge Clk);
        run <= 1'b1;
        @(posedge Clk);
        run <= 1'b0;
        @(negedge Clk);
        while (led == 12'h000) @(negedge Clk);
    endtask

    task automatic resumeUntilNextPause();
        logic [11:0] prevLed;
        prevLed = led;
        @(posedge Clk);
        resume <= 1'b1;
        @(posedge Clk);
        resume <= 1'b0;
        @(negedge Clk);
        while (led == prevLed) @(negedge Clk);
    endtask

    // ------------------------------
    // Directed tests
    // ------------------------------

    task automatic aluResults();
        slc3Pkg::word_t a, b;
        int imm1, imm2;
        a = slc3Pkg::word_t'($random(seed));
        b = slc3Pkg::word_t'($random(seed));
        imm1 = $random(seed) % 16;
        imm2 = $random(seed) % 16;
        progWords.delete();
        progWords.push_back(memOp(OpLdr, 1, 0, 24));
        progWords.push_back(memOp(OpLdr, 2, 0, 25));
        progWords.push_back(aluReg(OpAdd, 3, 1, 2));
        progWords.push_back(memOp(OpStr, 3, 0, 16));
        progWords.push_back(aluReg(OpAnd, 4, 1, 2));
        progWords.push_back(memOp(OpStr, 4, 0, 17));
        progWords.push_back(notReg(5, 1));
        progWords.push_back(memOp(OpStr, 5, 0, 18));
        progWords.push_back(aluImm(OpAdd, 6, 1, imm1));
        progWords.push_back(memOp(OpStr, 6, 0, 19));
        progWords.push_back(aluImm(OpAnd, 7, 2, imm2));
        progWords.push_back(memOp(OpStr, 7, 0, 20));
        progWords.push_back(pauseCode('h001));
        applyReset();
        loadProgram();
        mem[16'd24] = a;
        mem[16'd25] = b;
        runUntilPause();
        checkWord("led", 16'h0001, {4'h0, led});
        checkWord("mem[0010] ADD", a + b, mem[16'd16]);
        checkWord("mem[0011] AND", a & b, mem[16'd17]);
        checkWord("mem[0012] NOT", ~a, mem[16'd18]);
        checkWord("mem[0013] ADD imm", a + immValue(imm1), mem[16'd19]);
        checkWord("mem[0014] AND imm", b & immValue(imm2), mem[16'd20]);
    endtask

    // Base R1 = 30 with offsets on both sides of it
    task automatic loadStoreCopy();
        slc3Pkg::word_t src1, src2;
        src1 = slc3Pkg::word_t'($random(seed));
        src2 = slc3Pkg::word_t'($random(seed));
        progWords.delete();
        progWords.push_back(aluImm(OpAdd, 1, 0, 15));
        progWords.push_back(aluImm(OpAdd, 1, 1, 15));
        progWords.push_back(memOp(OpLdr, 2, 1, -4));
        progWords.push_back(memOp(OpStr, 2, 1, -9));
        progWords.push_back(memOp(OpLdr, 3, 1, 1));
        progWords.push_back(memOp(OpStr, 3, 1, -10));
        progWords.push_back(pauseCode('h002));
        applyReset();
        loadProgram();
        mem[offsetAddr(16'd30, -4)] = src1;
        mem[offsetAddr(16'd30, 1)] = src2;
        runUntilPause();
        checkWord("led", 16'h0002, {4'h0, led});
        checkWord("mem[base-9]", src1, mem[offsetAddr(16'd30, -9)]);
        checkWord("mem[base-10]", src2, mem[offsetAddr(16'd30, -10)]);
    endtask

    // Each case loads a value and branches over a marker STR or not
    task automatic branchMasks();
        slc3Pkg::word_t vals [3];
        slc3Pkg::word_t marker, markAddr;
        int masks [4];
        logic taken;
        vals[0] = slc3Pkg::word_t'($random(seed)) | 16'h8000;
        vals[1] = 16'h0000;
        vals[2] = (slc3Pkg::word_t'($random(seed)) & 16'h7FFF) | 16'h0001;
        masks = '{4, 2, 1, 0};
        masks[3] = $random(seed) & 7;
        marker = slc3Pkg::word_t'($random(seed));
        progWords.delete();
        // R6 = 60 as data base
        progWords.push_back(aluImm(OpAdd, 6, 0, 15));
        progWords.push_back(aluReg(OpAdd, 6, 6, 6));
        progWords.push_back(aluReg(OpAdd, 6, 6, 6));
        progWords.push_back(memOp(OpLdr, 7, 6, 7));
        for (int vi = 0; vi < 3; vi++) begin
            for (int mi = 0; mi < 4; mi++) begin
                progWords.push_back(memOp(OpLdr, 1, 6, 4 + vi));
                progWords.push_back(branch(masks[mi], 1));
                progWords.push_back(memOp(OpStr, 7, 6, 10 + vi * 4 + mi));
            end
        end
        progWords.push_back(pauseCode('h003));
        applyReset();
        loadProgram();
        for (int vi = 0; vi < 3; vi++) begin
            mem[16'd64 + 16'(vi)] = vals[vi];
        end
        mem[16'd67] = marker;
        runUntilPause();
        checkWord("led", 16'h0003, {4'h0, led});
        for (int vi = 0; vi < 3; vi++) begin
            for (int mi = 0; mi < 4; mi++) begin
                markAddr = 16'd70 + 16'(vi * 4 + mi);
                taken = |(3'(masks[mi]) & nzpOf(vals[vi]));
                checkWord($sformatf("mem[%h]", markAddr),
                    taken ? fillWord(markAddr) : marker, mem[markAddr]);
            end
        end
    endtask

    task automatic jumpToRegister();
        slc3Pkg::word_t target, marker;
        target = 16'd20;
        marker = slc3Pkg::word_t'($random(seed));
        progWords.delete();
        progWords.push_back(aluImm(OpAdd, 2, 0, 15));
        progWords.push_back(aluImm(OpAdd, 2, 2, 5));
        progWords.push_back(memOp(OpLdr, 3, 0, 31));
        progWords.push_back(jump(2));
        // Skipped by the jump
        progWords.push_back(memOp(OpStr, 3, 0, 28));
        progWords.push_back(pauseCode('h0EE));
        applyReset();
        loadProgram();
        mem[target] = memOp(OpStr, 3, 0, 29);
        mem[target + 16'd1] = pauseCode('h004);
        mem[16'd31] = marker;
        runUntilPause();
        checkWord("led", 16'h0004, {4'h0, led});
        checkWord("mem[001c]", fillWord(16'd28), mem[16'd28]);
        checkWord("mem[001d]", marker, mem[16'd29]);
        // PC already past the PAUSE at target + 1
        checkWord("pc", target + 16'd2, pc);
    endtask

    task automatic pauseAndResume();
        int code1, code2;
        code1 = ($random(seed) & 'hFFF) | 1;
        code2 = code1 ^ 'h0F0;
        progWords.delete();
        progWords.push_back(pauseCode(code1));
        progWords.push_back(aluImm(OpAdd, 1, 0, 7));
        progWords.push_back(memOp(OpStr, 1, 0, 20));
        progWords.push_back(pauseCode(code2));
        applyReset();
        loadProgram();
        runUntilPause();
        checkWord("led", 16'(code1), {4'h0, led});
        checkWord("pc", 16'd1, pc);
        resumeUntilNextPause();
        checkWord("led", 16'(code2), {4'h0, led});
        checkWord("mem[0014]", 16'd7, mem[16'd20]);
    endtask

    task automatic ioWordAccess();
        slc3Pkg::word_t swVal, hexWord;
        swVal = slc3Pkg::word_t'($random(seed));
        hexWord = slc3Pkg::word_t'($random(seed));
        progWords.delete();
        // R1 = FFFF
        progWords.push_back(aluImm(OpAdd, 1, 0, -1));
        progWords.push_back(memOp(OpLdr, 2, 1, 0));
        progWords.push_back(memOp(OpStr, 2, 0, 20));
        progWords.push_back(memOp(OpLdr, 3, 0, 21));
        progWords.push_back(memOp(OpStr, 3, 1, 0));
        progWords.push_back(pauseCode('h006));
        applyReset();
        loadProgram();
        mem[16'd21] = hexWord;
        @(posedge Clk);
        switches <= swVal;
        runUntilPause();
        checkWord("led", 16'h0006, {4'h0, led});
        checkWord("mem[0014] switches", swVal, mem[16'd20]);
        checkWord("hexValue", hexWord, hexValue);
        checkWord("mem[ffff]", fillWord(`SLC3_IO_ADDR), mem[`SLC3_IO_ADDR]);
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------

    initial begin
        arstN <= 1'b0;
        run <= 1'b0;
        resume <= 1'b0;
        switches <= 16'h0000;
        aluResults();
        loadStoreCopy();
        branchMasks();
        jumpToRegister();
        pauseAndResume();
        ioWordAccess();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* all.f */
+incdir+hdl
hdl/slc3Pkg.sv
hdl/regFile.sv
hdl/datapath.sv
hdl/controlUnit.sv
hdl/memBridge.sv
hdl/slc3.sv
test/slc3Tb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the SLC-3 testbench with Verilator, runs it and checks the log for a pass
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f all.f --top-module slc3Tb -o slc3Sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/slc3Sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "No errors" "$LOG"; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1
